//--- list.f
+incdir+logic
logic/dcache_pkg.sv
logic/cache_ctrl_fsm.sv
logic/wb_beat_counter.sv
logic/writeback_buffer.sv
logic/cache_ways.sv
logic/lru_ages.sv
logic/dcache_top.sv
verif/tb_mem_model.sv
verif/tb_dcache.sv

//--- Makefile
SIM   := verilator
FLAGS := --binary --timing --assert -Wno-fatal
TOP   := tb_dcache
FLIST := list.f
OBJ   := obj_dir
BIN   := $(OBJ)/V$(TOP)
LOG   := sim.log
SRCS  := $(wildcard logic/*.sv logic/*.svh verif/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

//--- verif/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache import dcache_pkg::*; ();

  localparam int N_COLD  = 16;
  localparam int N_PAIRS = 40;
  localparam int N_MIX   = 500;
  localparam int N_WORDS = 768; // 12 tags x 8 sets x 8 words
  localparam int TIMEOUT_CYCLES = 200 * (N_COLD + 2 * N_PAIRS + N_MIX + N_WORDS);

  logic        clk, rst;
  logic        cpu_req_valid, cpu_req_ready, cpu_rsp_valid, cpu_rsp_ready;
  dc_cpu_req_t cpu_req;
  word_t       cpu_rsp_data, mem_rd_rsp_data;
  logic        mem_rd_req_valid, mem_rd_req_ready, mem_rd_rsp_valid;
  logic        mem_rd_rsp_last, mem_rd_rsp_ready;
  logic        mem_wr_req_valid, mem_wr_req_ready, mem_wr_data_valid, mem_wr_data_ready;
  dc_addr_u    mem_rd_req_addr, mem_wr_req_addr;
  dc_wr_beat_t mem_wr_data;
  int          wb_bursts;

  // reference model: latest word values plus a shadow of tags and ages
  word_t ref_mem [N_WORDS];
  logic  touched [N_WORDS];
  logic  m_valid [8][6];
  logic  m_dirty [8][6];
  int    m_tag   [8][6];
  int    m_age   [8][6];
  int    checks, errors, exp_wbs, n_req, cycle_cnt;
  int    t_checks, t_errors; // counts at the start of the running test

  dcache_top   u_dcache_top (.*);
  tb_mem_model u_mem (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // same fill rule as the memory's initial content
  function automatic word_t fill_word(input logic [31:0] byte_addr);
    return (byte_addr * 32'h9e37_79b1) ^ 32'h5bd1_e995;
  endfunction

  function automatic logic [31:0] rand_addr();
    logic [23:0] tag;
    logic [2:0]  s;
    logic [2:0]  w;
    tag = 24'($urandom % 12); // 12 tags against 6 ways forces evictions
    s   = 3'($urandom);
    w   = 3'($urandom);
    return {tag, s, w, 2'b00};
  endfunction

  function automatic int find_way(input int s, input int tag);
    for (int w = 0; w < 6; w++) begin
      if (m_valid[s][w] && m_tag[s][w] == tag) return w; // lowest way first
    end
    return -1;
  endfunction

  function automatic int oldest_way(input int s);
    for (int w = 0; w < 6; w++) begin
      if (m_age[s][w] == 5) return w;
    end
    return 0;
  endfunction

  task automatic age_touch(input int s, input int way);
    int hit_age;
    hit_age = m_age[s][way];
    for (int w = 0; w < 6; w++) begin
      if (w == way) m_age[s][w] = 0;
      else if (m_age[s][w] < hit_age) m_age[s][w]++; // younger ways move up one
    end
  endtask

  task automatic note_error(input string msg);
    errors++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic check_word(input word_t got, input word_t exp, input logic [31:0] addr);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t read of %h returned %h, expected %h", $time, addr, got, exp);
    end
  endtask

  task automatic check_wb_addr(input dc_addr_u got, input dc_addr_u exp);
    checks++;
    if (got.raw !== exp.raw) begin
      errors++;
      $display("FAIL t=%0t write-back address %h, expected %h", $time, got.raw, exp.raw);
    end
  endtask

  task automatic check_rd_addr(input dc_addr_u got, input dc_addr_u exp);
    checks++;
    if (got.raw !== exp.raw) begin
      errors++;
      $display("FAIL t=%0t refill address %h, expected %h", $time, got.raw, exp.raw);
    end
  endtask

  task automatic check_beat(input dc_wr_beat_t got, input dc_wr_beat_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t write-back beat %h last %b, expected %h last %b",
               $time, got.data, got.last, exp.data, exp.last);
    end
  endtask

  // one cpu request, predicted by the model and watched on every channel
  task automatic run_request(input logic we, input logic [31:0] addr);
    dc_cpu_req_t req;
    dc_addr_u    exp_wb;
    dc_addr_u    exp_rd;
    dc_wr_beat_t exp_beat;
    word_t       held;
    int          s, tag, wi, way, cycles, beats, wr_reqs;
    logic        exp_hit, exp_dirty, rd_seen, held_ok, done, in_refill;
    s          = int'(addr[7:5]);
    tag        = int'(addr[31:8]);
    wi         = int'(addr[11:2]);
    way        = find_way(s, tag);
    exp_hit    = (way >= 0);
    exp_dirty  = 1'b0;
    exp_wb.raw = '0;
    exp_rd.raw = {24'(tag), 3'(s), 5'd0}; // line of the request
    if (!exp_hit) begin
      way        = oldest_way(s); // lru victim
      exp_dirty  = m_valid[s][way] && m_dirty[s][way];
      exp_wb.raw = {24'(m_tag[s][way]), 3'(s), 5'd0};
      m_valid[s][way] = 1'b1;
      m_tag[s][way]   = tag;
      m_dirty[s][way] = 1'b0;
    end
    age_touch(s, way);
    if (we) m_dirty[s][way] = 1'b1; // write hit or write-allocate leaves the line dirty
    if (exp_dirty) exp_wbs++;
    req.we       = we;
    req.addr.raw = addr;
    req.wdata    = $urandom;
    req.wstrb    = 4'($urandom);
    @(posedge clk);
    cpu_req       <= req;
    cpu_req_valid <= 1'b1;
    n_req++;
    cycles    = 0;
    beats     = 0;
    wr_reqs   = 0;
    rd_seen   = 1'b0;
    done      = 1'b0;
    in_refill = 1'b0;
    while (!done) begin
      @(posedge clk);
      cycles++;
      if (mem_rd_rsp_ready !== in_refill)
        note_error($sformatf("refill ready was %b while the refill window was %b",
                             mem_rd_rsp_ready, in_refill));
      if (exp_hit && (mem_rd_req_valid || mem_wr_req_valid))
        note_error($sformatf("memory request during a predicted hit to %h", addr));
      if (mem_wr_req_valid && mem_wr_req_ready) begin
        wr_reqs++;
        check_wb_addr(mem_wr_req_addr, exp_wb);
      end
      if (mem_wr_data_valid && mem_wr_data_ready) begin
        if (!exp_dirty || beats > 7) begin
          note_error("write-back beat that the model did not expect");
        end else begin
          exp_beat.data = ref_mem[int'(exp_wb.raw[11:2]) + beats]; // ascending words
          exp_beat.last = (beats == 7);
          check_beat(mem_wr_data, exp_beat);
        end
        beats++;
      end
      if (mem_rd_req_valid && mem_rd_req_ready) begin
        rd_seen   = 1'b1;
        in_refill = 1'b1; // beats may be taken from the next cycle on
        check_rd_addr(mem_rd_req_addr, exp_rd);
        if (exp_dirty && beats != 8) note_error("refill requested before the write-back ended");
      end
      if (mem_rd_rsp_valid && mem_rd_rsp_ready && mem_rd_rsp_last) in_refill = 1'b0;
      if (cpu_req_ready) begin
        cpu_req_valid <= 1'b0;
        done = 1'b1;
      end
    end
    if (exp_hit && cycles != 2)
      note_error($sformatf("hit to %h took %0d cycles instead of 2", addr, cycles));
    if (!exp_hit && !rd_seen) note_error($sformatf("miss to %h ended without a refill", addr));
    if (wr_reqs != (exp_dirty ? 1 : 0) || (exp_dirty && beats != 8))
      note_error($sformatf("miss to %h gave %0d write-backs with %0d beats", addr, wr_reqs, beats));
    touched[wi] = 1'b1;
    if (we) begin
      for (int b = 0; b < 4; b++) begin
        if (req.wstrb[b]) ref_mem[wi][8*b +: 8] = req.wdata[8*b +: 8]; // strobed bytes only
      end
    end else begin
      held_ok = 1'b0;
      done    = 1'b0;
      while (!done) begin
        @(posedge clk);
        if (cpu_rsp_valid) begin
          if (held_ok && cpu_rsp_data !== held) note_error("read data moved during a stall");
          held    = cpu_rsp_data;
          held_ok = 1'b1;
          if (cpu_rsp_ready) begin
            check_word(cpu_rsp_data, ref_mem[wi], addr);
            done = 1'b1;
          end
        end
        cpu_rsp_ready <= !done && ($urandom % 2 == 0); // random back-pressure
      end
    end
  endtask

  task automatic end_test(input string name);
    $display("test %s: %0d checks, %0d errors", name, checks - t_checks, errors - t_errors);
    t_checks = checks;
    t_errors = errors;
  endtask

  initial begin
    logic [31:0] a;
    void'($urandom(32'hdc26));
    rst           = 1'b1;
    cpu_req_valid = 1'b0;
    cpu_req       = '0;
    cpu_rsp_ready = 1'b0;
    {checks, errors, exp_wbs, n_req, t_checks, t_errors} = '0;
    for (int i = 0; i < N_WORDS; i++) begin
      ref_mem[i] = fill_word(32'(i) << 2);
      touched[i] = 1'b0;
    end
    for (int s = 0; s < 8; s++) begin
      for (int w = 0; w < 6; w++) begin
        m_valid[s][w] = 1'b0;
        m_dirty[s][w] = 1'b0;
        m_tag[s][w]   = 0;
        m_age[s][w]   = w; // matches the reset ordering
      end
    end
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < N_COLD; i++) run_request(1'b0, rand_addr());
    end_test("cold reads");
    for (int i = 0; i < N_PAIRS; i++) begin
      a = rand_addr();
      run_request(1'b1, a);
      run_request(1'b0, a);
    end
    end_test("write then read");
    for (int i = 0; i < N_MIX; i++) run_request(1'($urandom), rand_addr());
    end_test("random mix");
    for (int i = 0; i < N_WORDS; i++) begin
      if (touched[i]) run_request(1'b0, 32'(i) << 2);
    end
    end_test("final readback");
    if (wb_bursts != exp_wbs)
      note_error($sformatf("memory took %0d write-backs, model expected %0d", wb_bursts, exp_wbs));
    $display("summary: %0d requests, %0d checks, %0d write-backs, %0d errors",
             n_req, checks, exp_wbs, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // watchdog sized from the request count
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model import dcache_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  // read channel, always 8-beat bursts
  input  logic        mem_rd_req_valid,
  input  dc_addr_u    mem_rd_req_addr,
  output logic        mem_rd_req_ready,
  output logic        mem_rd_rsp_valid,
  output word_t       mem_rd_rsp_data,
  output logic        mem_rd_rsp_last,
  input  logic        mem_rd_rsp_ready,
  // write channel
  input  logic        mem_wr_req_valid,
  input  dc_addr_u    mem_wr_req_addr,
  output logic        mem_wr_req_ready,
  input  logic        mem_wr_data_valid,
  input  dc_wr_beat_t mem_wr_data,
  output logic        mem_wr_data_ready,
  output int          wb_bursts // completed write-back bursts, seen by the testbench
);

  localparam int MEM_WORDS = 1024;

  word_t      mem [MEM_WORDS]; // backing store, word addressed
  logic       rd_busy;
  logic       wr_busy;
  logic [9:0] rd_base;         // word index of the line start
  logic [9:0] wr_base;
  int         rd_beat;
  int         rd_next;
  int         wr_beat;

  // initial content, every address bit matters
  function automatic word_t fill_word(input logic [31:0] byte_addr);
    return (byte_addr * 32'h9e37_79b1) ^ 32'h5bd1_e995;
  endfunction

  // read side: accept the line address, then 8 beats with random gaps
  always @(posedge clk) begin
    if (rst) begin
      rd_busy          <= 1'b0;
      rd_beat          <= 0;
      mem_rd_req_ready <= 1'b0;
      mem_rd_rsp_valid <= 1'b0;
      mem_rd_rsp_last  <= 1'b0;
      mem_rd_rsp_data  <= '0;
    end else if (!rd_busy) begin
      if (mem_rd_req_valid && mem_rd_req_ready) begin
        rd_busy          <= 1'b1;
        rd_base          <= mem_rd_req_addr.raw[11:2];
        rd_beat          <= 0;
        mem_rd_req_ready <= 1'b0;
      end else begin
        mem_rd_req_ready <= ($urandom % 3 != 0);
      end
    end else begin
      rd_next = rd_beat + ((mem_rd_rsp_valid && mem_rd_rsp_ready) ? 1 : 0);
      rd_beat <= rd_next;
      if (rd_next == 8) begin
        rd_busy          <= 1'b0;
        mem_rd_rsp_valid <= 1'b0;
        mem_rd_rsp_last  <= 1'b0;
      end else begin
        // a beat that is shown but not taken stays up
        mem_rd_rsp_valid <= (mem_rd_rsp_valid && !mem_rd_rsp_ready) || ($urandom % 4 != 0);
        mem_rd_rsp_data  <= mem[int'(rd_base) + rd_next];
        mem_rd_rsp_last  <= (rd_next == 7);
      end
    end
  end

  // write side: accept the line address, then store 8 beats in order
  always @(posedge clk) begin
    if (rst) begin
      wr_busy           <= 1'b0;
      wr_beat           <= 0;
      wb_bursts         <= 0;
      mem_wr_req_ready  <= 1'b0;
      mem_wr_data_ready <= 1'b0;
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= fill_word(32'(i) << 2);
      end
    end else if (!wr_busy) begin
      if (mem_wr_req_valid && mem_wr_req_ready) begin
        wr_busy           <= 1'b1;
        wr_base           <= mem_wr_req_addr.raw[11:2];
        wr_beat           <= 0;
        mem_wr_req_ready  <= 1'b0;
        mem_wr_data_ready <= 1'($urandom);
      end else begin
        mem_wr_req_ready <= ($urandom % 3 != 0);
      end
    end else if (mem_wr_data_valid && mem_wr_data_ready) begin
      mem[int'(wr_base) + wr_beat] <= mem_wr_data.data;
      wr_beat <= wr_beat + 1;
      if (wr_beat == 7) begin // burst length is fixed
        wr_busy           <= 1'b0;
        wb_bursts         <= wb_bursts + 1;
        mem_wr_data_ready <= 1'b0;
      end else begin
        mem_wr_data_ready <= 1'($urandom);
      end
    end else begin
      mem_wr_data_ready <= 1'($urandom); // stall some beats
    end
  end

endmodule

`default_nettype wire

//--- logic/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_top import dcache_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  // cpu request and response
  input  logic        cpu_req_valid,
  input  dc_cpu_req_t cpu_req,
  output logic        cpu_req_ready,
  output logic        cpu_rsp_valid,
  output word_t       cpu_rsp_data,
  input  logic        cpu_rsp_ready,
  // memory read channel
  output logic        mem_rd_req_valid,
  output dc_addr_u    mem_rd_req_addr,
  input  logic        mem_rd_req_ready,
  input  logic        mem_rd_rsp_valid,
  input  word_t       mem_rd_rsp_data,
  input  logic        mem_rd_rsp_last,
  output logic        mem_rd_rsp_ready,
  // memory write channel, always 8-beat bursts
  output logic        mem_wr_req_valid,
  output dc_addr_u    mem_wr_req_addr,
  input  logic        mem_wr_req_ready,
  output logic        mem_wr_data_valid,
  output dc_wr_beat_t mem_wr_data,
  input  logic        mem_wr_data_ready
);

  logic                 hit;
  dc_way_t              hit_way;
  word_t                hit_word;
  logic [`DC_TAG_W-1:0] victim_tag;
  logic                 victim_dirty;
  dc_line_t             victim_line;
  dc_way_t              victim_way;
  logic                 hit_write, refill_beat, touch;
  logic                 wb_capture, beat_fire, last_beat;
  word_t                wb_word;

  // line aligned burst addresses
  assign mem_rd_req_addr.raw = {cpu_req.addr.f.tag, cpu_req.addr.f.index, `DC_OFFSET_W'(0)};
  assign mem_wr_req_addr.raw = {victim_tag, cpu_req.addr.f.index, `DC_OFFSET_W'(0)};
  assign mem_wr_data         = '{data: wb_word, last: last_beat};
  assign cpu_rsp_data        = hit_word; // valid only with cpu_rsp_valid

  cache_ctrl_fsm u_fsm (
    .clk, .rst,
    .cpu_req_valid, .cpu_we (cpu_req.we), .cpu_req_ready,
    .cpu_rsp_valid, .cpu_rsp_ready,
    .hit, .victim_dirty,
    .mem_rd_req_valid, .mem_rd_req_ready,
    .mem_rd_rsp_valid, .mem_rd_rsp_last, .mem_rd_rsp_ready,
    .mem_wr_req_valid, .mem_wr_req_ready,
    .mem_wr_data_valid, .mem_wr_data_ready, .last_beat,
    .hit_write, .refill_beat, .touch, .wb_capture, .beat_fire
  );

  wb_beat_counter u_wb_cnt (.clk, .rst, .beat_fire, .last_beat);

  writeback_buffer u_wb_buf (
    .clk, .rst, .wb_capture, .victim_line, .beat_fire, .wb_word
  );

  cache_ways u_ways (
    .clk, .rst, .cpu_req, .victim_way, .hit_write, .refill_beat,
    .refill_data (mem_rd_rsp_data),
    .hit, .hit_way, .hit_word, .victim_tag, .victim_dirty, .victim_line
  );

  lru_ages u_lru (
    .clk, .rst, .index (cpu_req.addr.f.index), .touch, .hit_way, .victim_way
  );

endmodule

`default_nettype wire

//--- logic/lru_ages.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module lru_ages import dcache_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`DC_INDEX_W-1:0] index,
  input  logic                   touch,    // hit state, way just used
  input  dc_way_t                hit_way,
  output dc_way_t                victim_way
);

  // age 0 is most recent, DC_WAYS-1 is the oldest
  logic [`DC_AGE_W-1:0] age_q [`DC_SETS][`DC_WAYS];
  logic [`DC_AGE_W-1:0] hit_age;
  logic [`DC_WAYS-1:0]  is_oldest;

  assign hit_age = age_q[index][hit_way];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < `DC_SETS; s++) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
          age_q[s][w] <= `DC_AGE_W'(w); // start as a valid permutation
        end
      end
    end else if (touch) begin
      for (int w = 0; w < `DC_WAYS; w++) begin
        if (dc_way_t'(w) == hit_way) begin
          age_q[index][w] <= '0;
        end else if (age_q[index][w] < hit_age) begin
          age_q[index][w] <= age_q[index][w] + 1'b1; // only younger ways move
        end
      end
    end
  end

  // victim is the way holding the top age
  always_comb begin
    victim_way = '0;
    for (int w = `DC_WAYS - 1; w >= 0; w--) begin
      is_oldest[w] = (age_q[index][w] == `DC_AGE_W'(`DC_WAYS - 1));
      if (is_oldest[w]) victim_way = dc_way_t'(w);
    end
  end

  // ages in a set stay a permutation across all updates
  a_one_oldest : assert property (@(posedge clk) disable iff (rst)
    $onehot(is_oldest));

endmodule

`default_nettype wire

//--- logic/cache_ways.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module cache_ways import dcache_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  dc_cpu_req_t          cpu_req,
  input  dc_way_t              victim_way,
  input  logic                 hit_write,
  input  logic                 refill_beat,
  input  word_t                refill_data,
  output logic                 hit,
  output dc_way_t              hit_way,
  output word_t                hit_word,
  output logic [`DC_TAG_W-1:0] victim_tag,
  output logic                 victim_dirty,
  output dc_line_t             victim_line
);

  // storage per way and set
  logic [`DC_SETS-1:0]  valid_q [`DC_WAYS];
  logic [`DC_SETS-1:0]  dirty_q [`DC_WAYS];
  logic [`DC_TAG_W-1:0] tag_q   [`DC_WAYS][`DC_SETS];
  dc_line_t             data_q  [`DC_WAYS][`DC_SETS];

  logic [`DC_INDEX_W-1:0] idx;
  logic [`DC_TAG_W-1:0]   req_tag;
  logic [2:0]             w_sel;       // word inside the line
  logic [`DC_WAYS-1:0]    way_hit;
  dc_line_t               hit_line;
  dc_line_t               merged_line;
  word_t                  merged_word;

  assign idx     = cpu_req.addr.f.index;
  assign req_tag = cpu_req.addr.f.tag;
  assign w_sel   = cpu_req.addr.f.word;

  // tag compare in every way of the selected set
  always_comb begin
    for (int w = 0; w < `DC_WAYS; w++) begin
      way_hit[w] = valid_q[w][idx] && (tag_q[w][idx] == req_tag);
    end
  end

  // priority encode, lowest way wins
  always_comb begin
    hit_way = '0;
    for (int w = `DC_WAYS - 1; w >= 0; w--) begin
      if (way_hit[w]) hit_way = dc_way_t'(w);
    end
  end

  assign hit      = |way_hit;
  assign hit_line = data_q[hit_way][idx];
  assign hit_word = hit_line[{w_sel, 5'b0} +: `DC_WORD_W]; // read data follows the request address

  // byte merge for a write hit
  always_comb begin
    merged_word = hit_word;
    for (int b = 0; b < 4; b++) begin
      if (cpu_req.wstrb[b]) merged_word[8*b +: 8] = cpu_req.wdata[8*b +: 8];
    end
    merged_line = hit_line;
    merged_line[{w_sel, 5'b0} +: `DC_WORD_W] = merged_word;
  end

  // victim side, index stays put for the whole miss
  assign victim_line  = data_q[victim_way][idx];
  assign victim_tag   = tag_q[victim_way][idx];
  assign victim_dirty = valid_q[victim_way][idx] && dirty_q[victim_way][idx];

  // line state bits
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int w = 0; w < `DC_WAYS; w++) begin
        valid_q[w] <= '0;
        dirty_q[w] <= '0;
      end
    end else if (refill_beat) begin
      valid_q[victim_way][idx] <= 1'b1; // new tag owns the line from the first beat
      dirty_q[victim_way][idx] <= 1'b0;
    end else if (hit_write) begin
      dirty_q[hit_way][idx] <= 1'b1;
    end
  end

  // tags and line data
  always_ff @(posedge clk) begin
    if (refill_beat) begin
      tag_q[victim_way][idx]  <= req_tag;
      // beats arrive in ascending order, shift in from the top
      data_q[victim_way][idx] <= {refill_data, victim_line[`DC_LINE_W-1:`DC_WORD_W]};
    end else if (hit_write) begin
      data_q[hit_way][idx] <= merged_line;
    end
  end

  // a tag may live in only one way of a set
  a_onehot_hit : assert property (@(posedge clk) disable iff (rst)
    $onehot0(way_hit));

endmodule

`default_nettype wire

//--- logic/writeback_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module writeback_buffer import dcache_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     wb_capture,  // write request accepted
  input  dc_line_t victim_line,
  input  logic     beat_fire,   // current word taken by memory
  output word_t    wb_word
);

  dc_line_t line_q; // victim snapshot, lowest word goes first

  always_ff @(posedge clk) begin
    if (wb_capture) begin
      line_q <= victim_line;
    end else if (beat_fire) begin
      // next ascending word moves into the output slot
      line_q <= {`DC_WORD_W'(0), line_q[`DC_LINE_W-1:`DC_WORD_W]};
    end
  end

  assign wb_word = line_q[`DC_WORD_W-1:0];

  // the fsm must not drain the buffer on the load edge
  a_no_fire_on_capture : assert property (@(posedge clk) disable iff (rst)
    wb_capture |-> !beat_fire);

endmodule

`default_nettype wire

//--- logic/wb_beat_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module wb_beat_counter (
  input  logic clk,
  input  logic rst,
  input  logic beat_fire, // accepted write-back beat
  output logic last_beat
);

  localparam int CNT_W = $clog2(`DC_BEATS);

  logic [CNT_W-1:0] cnt_q;

  // wraps after the eighth beat so every burst starts from zero
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_q <= '0;
    end else if (beat_fire) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign last_beat = (cnt_q == CNT_W'(`DC_BEATS - 1)); // also marks last on the bus

endmodule

`default_nettype wire

//--- logic/cache_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module cache_ctrl_fsm import dcache_pkg::*; (
  input  logic clk,
  input  logic rst,
  // cpu side
  input  logic cpu_req_valid,
  input  logic cpu_we,
  output logic cpu_req_ready,
  output logic cpu_rsp_valid,
  input  logic cpu_rsp_ready,
  // lookup results
  input  logic hit,
  input  logic victim_dirty,
  // memory read channel
  output logic mem_rd_req_valid,
  input  logic mem_rd_req_ready,
  input  logic mem_rd_rsp_valid,
  input  logic mem_rd_rsp_last,
  output logic mem_rd_rsp_ready,
  // memory write channel
  output logic mem_wr_req_valid,
  input  logic mem_wr_req_ready,
  output logic mem_wr_data_valid,
  input  logic mem_wr_data_ready,
  input  logic last_beat,
  // datapath strobes
  output logic hit_write,
  output logic refill_beat,
  output logic touch,
  output logic wb_capture,
  output logic beat_fire
);

  dc_state_e state_q;
  dc_state_e state_d;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (cpu_req_valid) begin // lookup is combinational on the held request
          if (hit) begin
            state_d = cpu_we ? W_HIT : R_HIT;
          end else begin
            state_d = victim_dirty ? WB_REQ : RF_REQ; // dirty victim goes out first
          end
        end
      end
      W_HIT:    state_d = IDLE; // merge happens on this edge
      R_HIT:    state_d = SEND_RSP;
      SEND_RSP: if (cpu_rsp_ready) state_d = IDLE;
      WB_REQ:   if (mem_wr_req_ready) state_d = WB_DATA;
      WB_DATA:  if (beat_fire && last_beat) state_d = RF_REQ; // eighth beat accepted
      RF_REQ:   if (mem_rd_req_ready) state_d = REFILL;
      REFILL: begin
        // line is in place after the last beat, replay as a hit
        if (mem_rd_rsp_valid && mem_rd_rsp_last) begin
          state_d = cpu_we ? W_HIT : R_HIT;
        end
      end
      default:  state_d = IDLE;
    endcase
  end

  // handshakes are pure state decode
  assign cpu_req_ready     = (state_q == W_HIT) || (state_q == R_HIT);
  assign cpu_rsp_valid     = (state_q == SEND_RSP); // held until cpu takes it
  assign mem_rd_req_valid  = (state_q == RF_REQ);
  assign mem_rd_rsp_ready  = (state_q == REFILL);
  assign mem_wr_req_valid  = (state_q == WB_REQ);
  assign mem_wr_data_valid = (state_q == WB_DATA);

  // one-cycle strobes to the datapath
  assign hit_write   = (state_q == W_HIT);
  assign refill_beat = (state_q == REFILL) && mem_rd_rsp_valid; // gaps allowed
  assign touch       = (state_q == W_HIT) || (state_q == R_HIT); // refilled line counts as used
  assign wb_capture  = (state_q == WB_REQ) && mem_wr_req_ready; // victim line snapshot
  assign beat_fire   = mem_wr_data_valid && mem_wr_data_ready;

  // a request only completes on a line that is present, refilled or not
  a_ready_on_hit : assert property (@(posedge clk) disable iff (rst)
    cpu_req_ready |-> hit);

  // victim stays dirty until its write-back burst is done
  a_wb_dirty_victim : assert property (@(posedge clk) disable iff (rst)
    (mem_wr_req_valid || mem_wr_data_valid) |-> victim_dirty);

endmodule

`default_nettype wire

//--- logic/dcache_pkg.sv
`default_nettype none

`include "dcache_defines.svh"

package dcache_pkg;

  typedef logic [`DC_WORD_W-1:0] word_t; // one cpu or memory word

  // cpu address split for the lookup
  typedef struct packed {
    logic [`DC_TAG_W-1:0]      tag;
    logic [`DC_INDEX_W-1:0]    index;
    logic [2:0]                word;     // word inside the line
    logic [1:0]                byte_off; // always zero for word access
  } dc_addr_fields_t;

  // raw view for compare and memory address, field view for lookup
  typedef union packed {
    logic [`DC_WORD_W-1:0] raw;
    dc_addr_fields_t       f;
  } dc_addr_u;

  typedef struct packed {
    logic     we;    // 1 = write
    dc_addr_u addr;
    word_t    wdata;
    logic [3:0] wstrb; // byte enables for writes
  } dc_cpu_req_t;

  typedef struct packed {
    word_t data;
    logic  last; // eighth beat of a write-back
  } dc_wr_beat_t;

  typedef logic [`DC_LINE_W-1:0] dc_line_t;
  typedef logic [`DC_WAY_W-1:0]  dc_way_t;

  typedef enum logic [2:0] {
    IDLE, W_HIT, R_HIT, SEND_RSP, WB_REQ, WB_DATA, RF_REQ, REFILL
  } dc_state_e;

endpackage

`default_nettype wire

//--- logic/dcache_defines.svh
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// cache geometry
`define DC_WAYS      6
`define DC_SETS      8
`define DC_INDEX_W   3   // log2 of sets
`define DC_OFFSET_W  5   // 32-byte lines

// address and data widths
`define DC_TAG_W     24  // 32 - index - offset
`define DC_WORD_W    32
`define DC_LINE_W    256 // 8 words per line
`define DC_BEATS     8   // words per memory burst

// replacement bookkeeping
`define DC_AGE_W     3   // ages 0 to 5
`define DC_WAY_W     3   // way number

`endif
